// ==== ldpc_decfail.f ====
ldpc_decfail_pkg.sv
ldpc_decfail_major_flag.sv
ldpc_decfail_row_cnt.sv
ldpc_decfail_decision.sv
ldpc_decfail_top.sv
ldpc_decfail_chk.sv
tb_ldpc_decfail.sv

// ==== ldpc_decfail_chk.sv ====
// ----------------------------------------------------------------------
// protocol and timing assertions, bound into the unit's top level
// sampled on the rising edge, an enabled cycle has clkena high
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ldpc_decfail_chk (
  input wire logic iclk,
  input wire logic arst_n,
  input wire logic clkena,
  input wire logic pre_val,
  input wire logic val_out,
  input wire logic decfail,
  input wire logic decfail_est
);

  // ----------------------------------------------------------------------
  // output pulse timing
  // ----------------------------------------------------------------------

  // val_out is pre_val delayed by one enabled cycle
  property val_out_follows_pre_val;
    @(posedge iclk) disable iff (!arst_n)
      clkena |=> (val_out == $past(pre_val));
  endproperty

  // passes span several beats, so the count strobe never repeats
  property pre_val_single;
    @(posedge iclk) disable iff (!arst_n)
      (clkena && pre_val) |=> !pre_val;
  endproperty

  // reset clears every pulse and flag at once
  property quiet_in_reset;
    @(posedge iclk)
      !arst_n |-> (!pre_val && !val_out && !decfail && !decfail_est);
  endproperty

  val_out_follows_a: assert property (val_out_follows_pre_val)
    else $error("val_out is not pre_val delayed by one enabled cycle");

  pre_val_single_a: assert property (pre_val_single)
    else $error("pre_val high on two consecutive enabled cycles");

  quiet_in_reset_a: assert property (quiet_in_reset)
    else $error("output active while reset is asserted");

endmodule

`default_nettype wire

// ==== ldpc_decfail_decision.sv ====
// ----------------------------------------------------------------------
// final and estimated failure decision with a two-deep stall history
// start must not coincide with cnt_val
// decfail_est is registered with val_out, one enabled cycle after cnt_val
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ldpc_decfail_decision
  import ldpc_decfail_pkg::*;
(
  input  wire logic      iclk,
  input  wire logic      arst_n,
  input  wire logic      clkena,
  // iteration control
  input  wire logic      start,
  input  wire logic      load_mode,
  // results of the two counting blocks
  input  wire logic      cnt_val,
  input  wire err_cnt_t  checks,
  input  wire logic      decfail,
  // decisions
  output logic           pre_val,
  output logic           val_out,
  output logic           decfail_est
);

  // ----------------------------------------------------------------------
  // stall history
  // ----------------------------------------------------------------------

  hist_state_t state;
  // count of the previous iteration
  err_cnt_t    hist_0;
  // count two iterations back
  err_cnt_t    hist_1;

  // fill level, cleared on a new codeword
  always_ff @(posedge iclk or negedge arst_n) begin
    if (!arst_n) begin
      state <= hist_empty;
    end else if (clkena && start) begin
      if (load_mode) begin
        state <= hist_empty;
      end else begin
        case (state)
          hist_empty: state <= hist_one;
          hist_one:   state <= hist_full;
          default:    state <= hist_full;
        endcase
      end
    end
  end

  // history payload shifts on every iteration start
  always_ff @(posedge iclk) begin
    if (clkena && start && !load_mode) begin
      hist_0 <= checks;
      hist_1 <= hist_0;
    end
  end

  // ----------------------------------------------------------------------
  // estimated failure
  // ----------------------------------------------------------------------

  // count unchanged over three iterations
  logic stalled;
  logic est_next;

  assign stalled = (checks == hist_0) && (hist_0 == hist_1);

  always_comb begin
    if (state == hist_full) begin
      // a stalled nonzero count is taken as success
      est_next = decfail | ((checks != '0) & ~stalled);
    end else begin
      est_next = decfail | (checks != '0);
    end
  end

  always_ff @(posedge iclk or negedge arst_n) begin
    if (!arst_n) begin
      val_out     <= 1'b0;
      decfail_est <= 1'b0;
    end else if (clkena) begin
      val_out <= cnt_val;
      // sampled when the count arrives, held in between
      if (cnt_val) begin
        decfail_est <= est_next;
      end
    end
  end

  // look-ahead of val_out
  assign pre_val = cnt_val;

endmodule

`default_nettype wire

// ==== ldpc_decfail_major_flag.sv ====
// ----------------------------------------------------------------------
// major-matrix failure flag, one value per decoder pass
// row_decfail and row_minfail are row-major, llr_by_cycle bits per row
// the flag is final one enabled cycle after the eop beat
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ldpc_decfail_major_flag #(
  parameter int llr_by_cycle = 4,
  parameter int row_by_cycle = 4
) (
  input  wire logic                                   iclk,
  input  wire logic                                   arst_n,
  input  wire logic                                   clkena,
  // beat strobes
  input  wire logic                                   val,
  input  wire logic                                   sop,
  // 1 selects a row of the major matrix
  input  wire logic [row_by_cycle-1:0]                pmask,
  input  wire logic [row_by_cycle*llr_by_cycle-1:0]   row_decfail,
  input  wire logic [row_by_cycle*llr_by_cycle-1:0]   row_minfail,
  output logic                                        decfail
);

  // ----------------------------------------------------------------------
  // per-row reduction
  // ----------------------------------------------------------------------

  // failure of each row, already gated by its mask bit
  logic [row_by_cycle-1:0] row_fail;
  // any masked row of this beat failed
  logic                    beat_fail;

  always_comb begin
    for (int row = 0; row < row_by_cycle; row++) begin
      // a failed check or a too-small minimum both count
      row_fail[row] = pmask[row] &
                      ((|row_decfail[row*llr_by_cycle +: llr_by_cycle]) |
                       (|row_minfail[row*llr_by_cycle +: llr_by_cycle]));
    end
  end

  assign beat_fail = |row_fail;

  // ----------------------------------------------------------------------
  // accumulation over the pass
  // ----------------------------------------------------------------------

  always_ff @(posedge iclk or negedge arst_n) begin
    if (!arst_n) begin
      decfail <= 1'b0;
    end else if (clkena) begin
      if (val) begin
        // sop starts a new pass, drop the old flag
        if (sop) begin
          decfail <= beat_fail;
        end else begin
          decfail <= decfail | beat_fail;
        end
      end
      // no beat, flag holds until the next sop
    end
  end

endmodule

`default_nettype wire

// ==== ldpc_decfail_pkg.sv ====
// ----------------------------------------------------------------------
// limits and types for the LDPC decoding-failure unit
// counts are sized for the largest 3GPP base graph and lifting size
// beat geometry is not here, it comes from module parameters
// ----------------------------------------------------------------------
`default_nettype none

package ldpc_decfail_pkg;

  // largest number of base-graph rows
  localparam int code_rows_max = 46;

  // largest lifting size
  localparam int zc_max = 384;

  // failed-check count must hold every check of the largest code
  localparam int err_cnt_w = $clog2(code_rows_max * zc_max + 1);

  // failed-check count of one codeword pass
  typedef logic [err_cnt_w-1:0] err_cnt_t;

  // stall history fill level
  // hist_full means two earlier counts are available for the stall compare
  typedef enum logic [1:0] {
    hist_empty = 2'd0,
    hist_one   = 2'd1,
    hist_full  = 2'd2
  } hist_state_t;

endpackage

`default_nettype wire

// ==== ldpc_decfail_row_cnt.sv ====
// ----------------------------------------------------------------------
// failed-check counter over all rows of the matrix
// only row_decfail counts, row_minfail is ignored here
// checks is valid with cnt_val, one enabled cycle after the eop beat
// row_by_cycle*llr_by_cycle must fit a count of err_cnt_w bits
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ldpc_decfail_row_cnt
  import ldpc_decfail_pkg::*;
#(
  parameter int llr_by_cycle = 4,
  parameter int row_by_cycle = 4
) (
  input  wire logic                                   iclk,
  input  wire logic                                   arst_n,
  input  wire logic                                   clkena,
  // beat strobes
  input  wire logic                                   val,
  input  wire logic                                   sop,
  input  wire logic                                   eop,
  input  wire logic [row_by_cycle*llr_by_cycle-1:0]   row_decfail,
  // final count of the pass
  output logic                                        cnt_val,
  output err_cnt_t                                    checks
);

  // check bits per beat
  localparam int bits_per_beat = row_by_cycle * llr_by_cycle;

  // ----------------------------------------------------------------------
  // beat popcount and running sum
  // ----------------------------------------------------------------------

  // set bits of the current beat
  err_cnt_t beat_cnt;
  // running sum of the pass so far
  err_cnt_t acc;
  // sum including the current beat
  err_cnt_t sum_next;

  always_comb begin
    beat_cnt = '0;
    for (int i = 0; i < bits_per_beat; i++) begin
      beat_cnt = beat_cnt + err_cnt_t'(row_decfail[i]);
    end
  end

  always_comb begin
    // sop restarts the sum from this beat
    if (sop) begin
      sum_next = beat_cnt;
    end else begin
      sum_next = acc + beat_cnt;
    end
  end

  // ----------------------------------------------------------------------
  // accumulator and output register
  // ----------------------------------------------------------------------

  always_ff @(posedge iclk or negedge arst_n) begin
    if (!arst_n) begin
      acc     <= '0;
      checks  <= '0;
      cnt_val <= 1'b0;
    end else if (clkena) begin
      // single enabled-cycle pulse after the eop beat
      cnt_val <= val & eop;
      if (val) begin
        acc <= sum_next;
        // total of the pass, held until the next eop
        if (eop) begin
          checks <= sum_next;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== ldpc_decfail_top.sv ====
// ----------------------------------------------------------------------
// LDPC decoding-failure and early-stop unit
// no back-pressure, every state holds while clkena is low
// latency: eop beat, pre_val one enabled cycle later, val_out one more
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ldpc_decfail_top
  import ldpc_decfail_pkg::*;
#(
  parameter int llr_by_cycle = 4,
  parameter int row_by_cycle = 4
) (
  input  wire logic                                   iclk,
  input  wire logic                                   arst_n,
  input  wire logic                                   clkena,
  // iteration control
  input  wire logic                                   start,
  input  wire logic                                   load_mode,
  // beat stream
  input  wire logic                                   val,
  input  wire logic                                   sop,
  input  wire logic                                   eop,
  input  wire logic [row_by_cycle-1:0]                pmask,
  input  wire logic [row_by_cycle*llr_by_cycle-1:0]   row_decfail,
  input  wire logic [row_by_cycle*llr_by_cycle-1:0]   row_minfail,
  // results
  output logic                                        pre_val,
  output logic                                        val_out,
  output err_cnt_t                                    checks,
  output logic                                        decfail,
  output logic                                        decfail_est
);

  // count strobe from the row counter
  logic cnt_val;

  // ----------------------------------------------------------------------
  // counting blocks, both see every beat
  // ----------------------------------------------------------------------

  // major-matrix flag, also the final decfail
  ldpc_decfail_major_flag #(
    .llr_by_cycle (llr_by_cycle),
    .row_by_cycle (row_by_cycle)
  ) major_flag_i (
    .iclk        (iclk),
    .arst_n      (arst_n),
    .clkena      (clkena),
    .val         (val),
    .sop         (sop),
    .pmask       (pmask),
    .row_decfail (row_decfail),
    .row_minfail (row_minfail),
    .decfail     (decfail)
  );

  // failed checks over the whole matrix
  ldpc_decfail_row_cnt #(
    .llr_by_cycle (llr_by_cycle),
    .row_by_cycle (row_by_cycle)
  ) row_cnt_i (
    .iclk        (iclk),
    .arst_n      (arst_n),
    .clkena      (clkena),
    .val         (val),
    .sop         (sop),
    .eop         (eop),
    .row_decfail (row_decfail),
    .cnt_val     (cnt_val),
    .checks      (checks)
  );

  // ----------------------------------------------------------------------
  // decision
  // ----------------------------------------------------------------------

  ldpc_decfail_decision decision_i (
    .iclk        (iclk),
    .arst_n      (arst_n),
    .clkena      (clkena),
    .start       (start),
    .load_mode   (load_mode),
    .cnt_val     (cnt_val),
    .checks      (checks),
    .decfail     (decfail),
    .pre_val     (pre_val),
    .val_out     (val_out),
    .decfail_est (decfail_est)
  );

endmodule

`default_nettype wire

// ==== run_ldpc_decfail.sh ====
#!/bin/sh
# build and run the LDPC decoding-failure testbench with Verilator
# the exit status is nonzero when the simulation ends in failure
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_ldpc_decfail \
  -f ldpc_decfail.f \
  -o sim_ldpc_decfail

./obj_dir/sim_ldpc_decfail

// ==== tb_ldpc_decfail.sv ====
// ----------------------------------------------------------------------
// testbench for the LDPC decoding-failure unit, default beat geometry
// plays the decoder: beats, iteration starts and clkena gaps
// expected results come from a pass model kept here
// inputs change on the falling edge, outputs are sampled on the rising
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_ldpc_decfail
  import ldpc_decfail_pkg::*;
();

  localparam int llr_by_cycle   = 4;
  localparam int row_by_cycle   = 4;
  localparam int beat_bits      = llr_by_cycle * row_by_cycle;
  // beats per codeword pass
  localparam int n_beats        = 4;
  // 40 passes of beats plus pipeline and start cycles, then a margin
  localparam int max_passes     = 40;
  localparam int timeout_cycles = max_passes * (n_beats + 4) + 100;

  logic                    iclk;
  logic                    arst_n;
  logic                    clkena;
  logic                    start;
  logic                    load_mode;
  logic                    val;
  logic                    sop;
  logic                    eop;
  logic [row_by_cycle-1:0] pmask;
  logic [beat_bits-1:0]    row_decfail;
  logic [beat_bits-1:0]    row_minfail;
  logic                    pre_val;
  logic                    val_out;
  err_cnt_t                checks;
  logic                    decfail;
  logic                    decfail_est;
  // all outputs side by side, for hold and reset compares
  logic [err_cnt_w+3:0]    outs;

  // beats of the pass being sent
  logic [beat_bits-1:0]    pass_dec  [n_beats];
  logic [beat_bits-1:0]    pass_min  [n_beats];
  logic [row_by_cycle-1:0] pass_mask [n_beats];

  // expected results, one entry per pass in flight
  err_cnt_t exp_checks [$];
  logic     exp_major  [$];
  logic     exp_est    [$];

  // model history of the decision block
  int       m_fill;
  err_cnt_t m_last;
  err_cnt_t m_h0;
  err_cnt_t m_h1;

  int       seed;
  int       n_sent = 0;
  int       n_checked = 0;
  int       cycle_cnt = 0;
  // sampler state
  logic                 eop_prev = 1'b0;
  logic                 gap_prev = 1'b0;
  logic [err_cnt_w+3:0] outs_prev = '0;
  err_cnt_t             exp_c;
  logic                 exp_m;
  logic                 exp_e;

  assign outs = {pre_val, val_out, checks, decfail, decfail_est};

  ldpc_decfail_top dut_i (
    .iclk        (iclk),
    .arst_n      (arst_n),
    .clkena      (clkena),
    .start       (start),
    .load_mode   (load_mode),
    .val         (val),
    .sop         (sop),
    .eop         (eop),
    .pmask       (pmask),
    .row_decfail (row_decfail),
    .row_minfail (row_minfail),
    .pre_val     (pre_val),
    .val_out     (val_out),
    .checks      (checks),
    .decfail     (decfail),
    .decfail_est (decfail_est)
  );

  bind ldpc_decfail_top ldpc_decfail_chk chk_i (
    .iclk        (iclk),
    .arst_n      (arst_n),
    .clkena      (clkena),
    .pre_val     (pre_val),
    .val_out     (val_out),
    .decfail     (decfail),
    .decfail_est (decfail_est)
  );

  initial begin
    iclk = 1'b0;
    forever begin
      #2 iclk = ~iclk;
    end
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  function automatic err_cnt_t count_ones(input logic [beat_bits-1:0] v);
    err_cnt_t n;
    n = '0;
    for (int i = 0; i < beat_bits; i++) begin
      if (v[i]) begin
        n++;
      end
    end
    return n;
  endfunction

  // popcount sum, masked major flag and estimate, from the pass rules
  task automatic predict_pass();
    err_cnt_t sum;
    logic     major;
    logic     est;
    sum = '0;
    major = 1'b0;
    for (int b = 0; b < n_beats; b++) begin
      sum = sum + count_ones(pass_dec[b]);
      for (int r = 0; r < row_by_cycle; r++) begin
        if (pass_mask[b][r] &&
            (pass_dec[b][r*llr_by_cycle +: llr_by_cycle] != '0 ||
             pass_min[b][r*llr_by_cycle +: llr_by_cycle] != '0)) begin
          major = 1'b1;
        end
      end
    end
    // a nonzero count that repeats over three iterations is a stall
    if (m_fill == 2) begin
      est = major || (sum != '0 && !(sum == m_h0 && m_h0 == m_h1));
    end else begin
      est = major || (sum != '0);
    end
    exp_checks.push_back(sum);
    exp_major.push_back(major);
    exp_est.push_back(est);
    m_last = sum;
    n_sent++;
  endtask

  task automatic drive_idle();
    val = 1'b0;
    sop = 1'b0;
    eop = 1'b0;
    pmask = '0;
    row_decfail = '0;
    row_minfail = '0;
  endtask

  // disabled cycles carrying junk beats that must be ignored
  task automatic insert_gap(input int n);
    clkena = 1'b0;
    val = 1'b1;
    sop = 1'b1;
    eop = 1'b1;
    row_decfail = beat_bits'($random(seed));
    row_minfail = beat_bits'($random(seed));
    repeat (n) @(negedge iclk);
    drive_idle();
    clkena = 1'b1;
  endtask

  task automatic send_pass(input logic gap_mid, input logic gap_end);
    predict_pass();
    for (int b = 0; b < n_beats; b++) begin
      val = 1'b1;
      sop = (b == 0);
      eop = (b == n_beats - 1);
      pmask = pass_mask[b];
      row_decfail = pass_dec[b];
      row_minfail = pass_min[b];
      @(negedge iclk);
      if (gap_mid && b == 1) begin
        insert_gap(3);
      end
    end
    drive_idle();
    if (gap_end) begin
      insert_gap(2);
    end
  endtask

  // the global cycle counter bounds this wait
  task automatic wait_drain();
    while (exp_est.size() != 0) begin
      @(negedge iclk);
    end
  endtask

  task automatic issue_start(input logic new_cw);
    start = 1'b1;
    load_mode = new_cw;
    @(negedge iclk);
    start = 1'b0;
    load_mode = 1'b0;
    if (new_cw) begin
      m_fill = 0;
    end else begin
      m_h1 = m_h0;
      m_h0 = m_last;
      if (m_fill < 2) begin
        m_fill++;
      end
    end
  endtask

  task automatic fill_zero(input logic [row_by_cycle-1:0] mask);
    for (int b = 0; b < n_beats; b++) begin
      pass_dec[b] = '0;
      pass_min[b] = '0;
      pass_mask[b] = mask;
    end
  endtask

  // n failed checks, all in row 0 of the beats
  task automatic fill_count(input int n, input logic [row_by_cycle-1:0] mask);
    fill_zero(mask);
    for (int i = 0; i < n; i++) begin
      pass_dec[i % n_beats][i / n_beats] = 1'b1;
    end
  endtask

  task automatic fill_random();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    for (int b = 0; b < n_beats; b++) begin
      r0 = $random(seed);
      r1 = $random(seed);
      r2 = $random(seed);
      // about one check in four fails, minfail is rarer
      pass_dec[b] = r0[beat_bits-1:0] & r1[beat_bits-1:0];
      pass_min[b] = r2[beat_bits-1:0] & r1[31:32-beat_bits] & r0[31:32-beat_bits];
      pass_mask[b] = r2[31:32-row_by_cycle];
    end
  endtask

  // ----------------------------------------------------------------------
  // output checks, sampled on the rising edge before it takes effect
  // ----------------------------------------------------------------------

  always @(posedge iclk) begin
    if (arst_n) begin
      if (gap_prev) begin
        assert (outs == outs_prev) else
          abort_run($sformatf("Mismatch at %0t: outputs expected %h, got %h",
                              $time, outs_prev, outs));
      end
      if (clkena) begin
        // pre_val one enabled cycle after the eop beat
        assert (pre_val == eop_prev) else
          abort_run($sformatf("Mismatch at %0t: pre_val expected %b, got %b",
                              $time, eop_prev, pre_val));
        if (pre_val) begin
          if (exp_checks.size() == 0) begin
            abort_run("pre_val pulsed with no pass outstanding");
          end else begin
            exp_c = exp_checks.pop_front();
            exp_m = exp_major.pop_front();
            assert (checks == exp_c) else
              abort_run($sformatf("Mismatch at %0t: checks expected %0d, got %0d",
                                  $time, exp_c, checks));
            assert (decfail == exp_m) else
              abort_run($sformatf("Mismatch at %0t: decfail expected %b, got %b",
                                  $time, exp_m, decfail));
          end
        end
        if (val_out) begin
          if (exp_est.size() == 0) begin
            abort_run("val_out pulsed with no pass outstanding");
          end else begin
            exp_e = exp_est.pop_front();
            assert (decfail_est == exp_e) else
              abort_run($sformatf("Mismatch at %0t: decfail_est expected %b, got %b",
                                  $time, exp_e, decfail_est));
            n_checked++;
          end
        end
        eop_prev = val & eop;
      end
    end else begin
      eop_prev = 1'b0;
    end
    gap_prev = arst_n & ~clkena;
    outs_prev = outs;
  end

  always @(posedge iclk) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles) begin
      abort_run($sformatf("timeout after %0d cycles with results outstanding", cycle_cnt));
    end
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------

  initial begin
    seed = 32'h45d9_2840;
    arst_n = 1'b0;
    clkena = 1'b1;
    start = 1'b0;
    load_mode = 1'b0;
    drive_idle();
    m_fill = 0;
    m_last = '0;
    m_h0 = '0;
    m_h1 = '0;
    repeat (3) @(negedge iclk);
    assert (outs == '0) else
      abort_run($sformatf("Mismatch at %0t: outputs expected 0, got %h", $time, outs));
    arst_n = 1'b1;
    @(negedge iclk);
    assert (outs == '0) else
      abort_run($sformatf("Mismatch at %0t: outputs expected 0, got %h", $time, outs));

    // random passes back to back, history stays empty
    repeat (16) begin
      fill_random();
      send_pass(1'b0, 1'b0);
    end
    wait_drain();

    // failures only in masked-off row 0, then one masked minfail
    issue_start(1'b1);
    fill_count(3, 4'b1110);
    pass_min[2][1] = 1'b1;
    send_pass(1'b0, 1'b0);
    fill_zero(4'b1111);
    pass_min[3][9] = 1'b1;
    send_pass(1'b0, 1'b0);
    // clean pass
    fill_zero(4'b1111);
    send_pass(1'b0, 1'b0);
    wait_drain();

    // stall over three iterations with the major flag clear
    issue_start(1'b1);
    fill_count(3, 4'b1110);
    send_pass(1'b0, 1'b0);
    wait_drain();
    issue_start(1'b0);
    send_pass(1'b0, 1'b0);
    wait_drain();
    issue_start(1'b0);
    send_pass(1'b0, 1'b0);
    wait_drain();
    // same stalled count but the major flag set
    issue_start(1'b0);
    fill_count(3, 4'b0001);
    send_pass(1'b0, 1'b0);
    wait_drain();
    // a differing third count
    issue_start(1'b0);
    fill_count(5, 4'b1110);
    send_pass(1'b0, 1'b0);
    wait_drain();

    // new codeword clears the history
    issue_start(1'b1);
    fill_count(3, 4'b1110);
    send_pass(1'b0, 1'b0);
    wait_drain();

    // the same pass without and with clkena gaps
    fill_random();
    send_pass(1'b0, 1'b0);
    wait_drain();
    send_pass(1'b1, 1'b1);
    wait_drain();
    repeat (2) @(negedge iclk);

    if (n_checked == n_sent && exp_checks.size() == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      abort_run("not every pass produced its results");
    end
  end

endmodule

`default_nettype wire
